// File: design/nx_bus_pkg.sv
// ====================
// Bus side definitions for the message link. Import this package wherever
// a stride crosses between the serializer and the receiver.
// ====================

package nx_bus_pkg;

    // Width of one stride on the link bus
    localparam int BUS_WIDTH = 8;

    // One bus transfer
    // data carries one byte of the message, lowest byte first
    // last marks the final stride of a message
    typedef struct packed {
        logic [BUS_WIDTH-1:0] data;
        logic                 last;
    } nx_stride_t;

endpackage : nx_bus_pkg

// File: design/nx_msg_pkg.sv
// ====================
// Message side definitions. Covers the word geometry, the transmit request
// and the serializer state. Import wherever whole message words are handled.
// ====================

package nx_msg_pkg;

    // Width of one message word
    localparam int MSG_WIDTH = 32;

    // Local copy of the bus stride width, kept equal to the bus package
    localparam int MSG_STRIDE_WIDTH = 8;

    // Strides needed to fill a word, rounded up
    localparam int MAX_TICKS = (MSG_WIDTH + MSG_STRIDE_WIDTH - 1) / MSG_STRIDE_WIDTH;

    // One extra bit so the counter can hold MAX_TICKS and beyond
    localparam int TICK_WIDTH = $clog2(MAX_TICKS) + 1;

    // One message word
    typedef logic [MSG_WIDTH-1:0] nx_word_t;

    // Transmit request
    // count is the number of strides to send, zero sends nothing
    typedef struct packed {
        logic [TICK_WIDTH-1:0] count;
        nx_word_t              data;
    } nx_tx_msg_t;

    // Serializer FSM
    typedef enum logic {
        SER_IDLE,
        SER_SEND
    } nx_ser_state_t;

endpackage : nx_msg_pkg

// File: design/nx_fifo.sv
// ====================
// Show-ahead FIFO for received message words. The head entry is always
// on rd_data_o while empty_o is low; rd_pop_i removes it.
// ====================

`timescale 1ns/1ps

module nx_fifo #(
    parameter int DEPTH = 2
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  nx_msg_pkg::nx_word_t wr_data_i,
    input  logic                 wr_push_i,
    output nx_msg_pkg::nx_word_t rd_data_o,
    input  logic                 rd_pop_i,
    output logic                 empty_o,
    output logic                 full_o
);

    import nx_msg_pkg::*;

    // Pointer needs at least one bit even for a single entry
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    // Word storage
    nx_word_t mem [DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr_q;
    logic [PTR_WIDTH-1:0] rd_ptr_q;
    logic [CNT_WIDTH-1:0] count_q;
    logic                 do_push;
    logic                 do_pop;

    // Ignore push when full and pop when empty
    assign do_push = wr_push_i && !full_o;
    assign do_pop  = rd_pop_i && !empty_o;

    assign empty_o   = (count_q == '0);
    assign full_o    = (count_q == CNT_WIDTH'(DEPTH));
    assign rd_data_o = mem[rd_ptr_q];

    // Write port
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    // Pointers wrap at DEPTH, occupancy tracks push minus pop
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the level unchanged
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule : nx_fifo

// File: design/nx_serializer.sv
// ====================
// Transmit side of the link. Accepts one message at a time and sends its
// stride count as bus strides, lowest byte first, last flagged.
// ====================

`timescale 1ns/1ps

module nx_serializer (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  nx_msg_pkg::nx_tx_msg_t tx_msg_i,
    input  logic                   tx_valid_i,
    output logic                   tx_ready_o,
    output nx_bus_pkg::nx_stride_t bus_stride_o,
    output logic                   bus_valid_o,
    input  logic                   bus_ready_i
);

    import nx_bus_pkg::*;
    import nx_msg_pkg::*;

    nx_ser_state_t         state_q;
    logic [TICK_WIDTH-1:0] remaining_q;
    nx_word_t              shift_q;
    logic                  tx_take;
    logic                  stride_move;
    logic                  is_last;

    // Only take a new message while idle
    assign tx_ready_o = (state_q == SER_IDLE);
    assign tx_take    = tx_valid_i && tx_ready_o;

    // Stride presented for the whole SER_SEND state
    assign bus_valid_o  = (state_q == SER_SEND);
    assign stride_move  = bus_valid_o && bus_ready_i;
    assign is_last      = (remaining_q == TICK_WIDTH'(1));

    // Low byte of the shifter is always the current stride
    assign bus_stride_o.data = shift_q[BUS_WIDTH-1:0];
    assign bus_stride_o.last = is_last;

    // FSM and stride counter
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= SER_IDLE;
            remaining_q <= '0;
        end else begin
            case (state_q)
                SER_IDLE: begin
                    // A zero count is consumed here and never leaves idle
                    if (tx_take && (tx_msg_i.count != '0)) begin
                        remaining_q <= tx_msg_i.count;
                        state_q     <= SER_SEND;
                    end
                end
                SER_SEND: begin
                    // Hold while the receiver stalls
                    if (stride_move) begin
                        remaining_q <= remaining_q - 1'b1;
                        if (is_last) begin
                            state_q <= SER_IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= SER_IDLE;
                end
            endcase
        end
    end

    // Data shifter
    // zero fill means strides past the word width carry zero
    always_ff @(posedge clk_i) begin
        if (tx_take) begin
            shift_q <= tx_msg_i.data;
        end else if (stride_move) begin
            shift_q <= shift_q >> BUS_WIDTH;
        end
    end

endmodule : nx_serializer

// File: design/nx_receiver.sv
// ====================
// Receive side of the link. Collects strides into a word aligned to the
// LSB, drops messages longer than one word, pushes the rest to the FIFO.
// ====================

`timescale 1ns/1ps

module nx_receiver (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  nx_bus_pkg::nx_stride_t bus_stride_i,
    input  logic                   bus_valid_i,
    output logic                   bus_ready_o,
    input  logic                   fifo_full_i,
    output logic                   push_o,
    output nx_msg_pkg::nx_word_t   push_data_o
);

    import nx_bus_pkg::*;
    import nx_msg_pkg::*;

    nx_word_t              accum_q, accum_d;
    logic [TICK_WIDTH-1:0] ticks_q, ticks_d;
    logic [TICK_WIDTH-1:0] pad;
    logic                  overflow_q, overflow_d;
    logic                  complete_q, complete_d;
    logic                  stride_move;

    // Stall the bus whenever the FIFO has no room
    assign bus_ready_o = !fifo_full_i;
    assign stride_move = bus_valid_i && bus_ready_o;

    // Overflowed messages complete but never push
    assign push_o      = complete_q && !overflow_q;
    assign push_data_o = accum_q;

    always_comb begin
        accum_d    = accum_q;
        ticks_d    = ticks_q;
        overflow_d = overflow_q;
        complete_d = 1'b0;
        pad        = '0;

        // One cycle after completion, start a fresh message
        if (complete_q) begin
            ticks_d    = '0;
            overflow_d = 1'b0;
        end

        if (stride_move) begin
            // Counter already full means this stride does not fit
            if (ticks_d >= TICK_WIDTH'(MAX_TICKS)) begin
                overflow_d = 1'b1;
            end else begin
                ticks_d = ticks_d + 1'b1;
            end

            // New byte enters at the top
            accum_d = {bus_stride_i.data, accum_d[MSG_WIDTH-1:BUS_WIDTH]};

            if (bus_stride_i.last) begin
                // Move a short message down to bit zero, zeros above it
                pad        = TICK_WIDTH'(MAX_TICKS) - ticks_d;
                accum_d    = accum_d >> (BUS_WIDTH * int'(pad));
                complete_d = 1'b1;
            end
        end
    end

    // Control state
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ticks_q    <= '0;
            overflow_q <= 1'b0;
            complete_q <= 1'b0;
        end else begin
            ticks_q    <= ticks_d;
            overflow_q <= overflow_d;
            complete_q <= complete_d;
        end
    end

    // Accumulator
    always_ff @(posedge clk_i) begin
        accum_q <= accum_d;
    end

endmodule : nx_receiver

// File: design/nx_link_top.sv
// ====================
// Top of the message link. Serializer feeds the receiver over the 8-bit
// bus, the receiver fills a two entry FIFO read by the sink.
// ====================

`timescale 1ns/1ps

module nx_link_top (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  nx_msg_pkg::nx_tx_msg_t tx_msg_i,
    input  logic                   tx_valid_i,
    output logic                   tx_ready_o,
    output nx_msg_pkg::nx_word_t   rx_data_o,
    output logic                   rx_valid_o,
    input  logic                   rx_ready_i
);

    import nx_bus_pkg::*;
    import nx_msg_pkg::*;

    // Internal bus
    nx_stride_t bus_stride;
    logic       bus_valid;
    logic       bus_ready;

    // Receiver to FIFO
    nx_word_t push_data;
    logic     push;
    logic     fifo_full;
    logic     fifo_empty;

    assign rx_valid_o = !fifo_empty;

    nx_serializer u_serializer (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .tx_msg_i     (tx_msg_i),
        .tx_valid_i   (tx_valid_i),
        .tx_ready_o   (tx_ready_o),
        .bus_stride_o (bus_stride),
        .bus_valid_o  (bus_valid),
        .bus_ready_i  (bus_ready)
    );

    nx_receiver u_receiver (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .bus_stride_i (bus_stride),
        .bus_valid_i  (bus_valid),
        .bus_ready_o  (bus_ready),
        .fifo_full_i  (fifo_full),
        .push_o       (push),
        .push_data_o  (push_data)
    );

    // Pop on the sink handshake
    nx_fifo #(
        .DEPTH (2)
    ) u_fifo (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .wr_data_i (push_data),
        .wr_push_i (push),
        .rd_data_o (rx_data_o),
        .rd_pop_i  (rx_valid_o && rx_ready_i),
        .empty_o   (fifo_empty),
        .full_o    (fifo_full)
    );

endmodule : nx_link_top

// File: dv/tb_nx_link.sv
// ====================
// Self-checking testbench for the message link. Reads messages from the
// tests file, predicts the received words and checks them under back-pressure.
// ====================

`timescale 1ns/1ps

module tb_nx_link;

    import nx_bus_pkg::*;
    import nx_msg_pkg::*;

    localparam int TIMEOUT_CYCLES = 1000;

    logic       clk;
    logic       arst_n_i;
    nx_tx_msg_t tx_msg_i;
    logic       tx_valid_i;
    logic       tx_ready_o;
    nx_word_t   rx_data_o;
    logic       rx_valid_o;
    logic       rx_ready_i;

    // Reference queue of words still owed by the DUT
    nx_word_t exp_q[$];
    int       total_expected;
    int       rcv_count;
    int       errors_value;
    int       errors_other;
    logic     cur_stall;

    nx_link_top u_dut (
        .clk_i      (clk),
        .arst_n_i   (arst_n_i),
        .tx_msg_i   (tx_msg_i),
        .tx_valid_i (tx_valid_i),
        .tx_ready_o (tx_ready_o),
        .rx_data_o  (rx_data_o),
        .rx_valid_o (rx_valid_o),
        .rx_ready_i (rx_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Expected word keeps the low bytes that were sent and zeros the rest
    function automatic nx_word_t aligned_word(input int strides, input nx_word_t data);
        nx_word_t result;
        int       b;
        result = '0;
        for (b = 0; b < MAX_TICKS; b++) begin
            if (b < strides) begin
                result[b*BUS_WIDTH +: BUS_WIDTH] = data[b*BUS_WIDTH +: BUS_WIDTH];
            end
        end
        return result;
    endfunction

    task automatic check_word(input nx_word_t got, input nx_word_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %08h expected %08h", $time, what, got, exp);
            errors_value++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAIL @%0t: %s got %0d expected %0d", $time, what, got, exp);
            errors_value++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
            errors_value++;
        end
    endtask

    // Called on a falling edge, returns on the falling edge where the link is idle
    task automatic wait_tx_ready(output bit ok);
        int i;
        ok = 1'b0;
        for (i = 0; i < TIMEOUT_CYCLES; i++) begin
            if (tx_ready_o) begin
                ok = 1'b1;
                break;
            end
            @(negedge clk);
        end
    endtask

    // Sink decides rx_ready_i on the falling edge and checks what pops next
    initial begin
        logic [31:0] rnd;
        nx_word_t    exp_word;
        rnd        = $urandom(28);
        rx_ready_i = 1'b0;
        forever begin
            @(negedge clk);
            if (!arst_n_i) begin
                rx_ready_i = 1'b0;
            end else if (cur_stall) begin
                rnd        = $urandom;
                rx_ready_i = rnd[0];
            end else begin
                rx_ready_i = 1'b1;
            end
            // Handshake inputs are settled until the next rising edge
            #1;
            if (rx_valid_o && rx_ready_i) begin
                rcv_count++;
                if (exp_q.size() == 0) begin
                    $display("Word %08h came out with no message outstanding", rx_data_o);
                    errors_other++;
                end else begin
                    exp_word = exp_q.pop_front();
                    check_word(rx_data_o, exp_word, "received word");
                end
            end
        end
    end

    initial begin
        int          fd;
        int          count_v;
        int          stall_v;
        logic [31:0] data_v;
        string       line;
        bit          ok;
        bit          aborted;
        int          i;

        arst_n_i       = 1'b0;
        tx_msg_i       = '0;
        tx_valid_i     = 1'b0;
        cur_stall      = 1'b0;
        total_expected = 0;
        rcv_count      = 0;
        errors_value   = 0;
        errors_other   = 0;
        aborted        = 1'b0;

        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        check_flag(tx_ready_o, 1'b1, "tx_ready_o after reset");
        check_flag(rx_valid_o, 1'b0, "rx_valid_o after reset");

        // Stride width copy in the message package must track the bus
        if (MSG_STRIDE_WIDTH != BUS_WIDTH) begin
            $display("Stride width in nx_msg_pkg does not match the bus width");
            errors_other++;
        end

        fd = $fopen("dv/nx_link_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file dv/nx_link_tests.txt");
            errors_other++;
            aborted = 1'b1;
        end

        while (!aborted && !$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // Comment and blank lines do not parse
            if ($sscanf(line, "%d %h %d", count_v, data_v, stall_v) != 3) begin
                continue;
            end
            wait_tx_ready(ok);
            if (!ok) begin
                $display("Timed out waiting for tx_ready_o before a message");
                errors_other++;
                aborted = 1'b1;
            end else begin
                // Only counts that fit a word produce a word
                if (count_v >= 1 && count_v <= MAX_TICKS) begin
                    exp_q.push_back(aligned_word(count_v, data_v));
                    total_expected++;
                end
                cur_stall     = (stall_v != 0);
                tx_msg_i.count = TICK_WIDTH'(count_v);
                tx_msg_i.data  = data_v;
                tx_valid_i    = 1'b1;
                @(negedge clk);
                tx_valid_i = 1'b0;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // Let the sink drain what is left
        if (!aborted) begin
            cur_stall = 1'b0;
            ok        = 1'b0;
            for (i = 0; i < TIMEOUT_CYCLES; i++) begin
                if (rcv_count >= total_expected) begin
                    ok = 1'b1;
                    break;
                end
                @(negedge clk);
            end
            if (!ok) begin
                $display("Timed out waiting for rx_valid_o to deliver the remaining words");
                errors_other++;
            end
            // Nothing extra may follow the last expected word
            repeat (8) @(negedge clk);
            check_flag(rx_valid_o, 1'b0, "rx_valid_o after drain");
            check_count(rcv_count, total_expected, "words received");
        end

        $display("errors: %0d value mismatches, %0d other failures", errors_value, errors_other);
        if (errors_value == 0 && errors_other == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_nx_link

// File: dv/nx_link_tests.txt
# count data stall
# count is strides 0..7, data is a 32-bit hex word, stall 1 makes rx_ready random
4 deadbeef 0
4 01234567 0
1 a5a5a5a5 0
2 cafef00d 0
3 87654321 0
5 11223344 0
4 55667788 0
7 ffffffff 0
0 12345678 0
2 0000beef 0
6 9abcdef0 1
4 13579bdf 1
3 2468ace0 1
4 fedcba98 1
1 000000ff 1
4 0badcafe 1
2 c0ffee11 1

// File: files.f
design/nx_bus_pkg.sv
design/nx_msg_pkg.sv
design/nx_fifo.sv
design/nx_serializer.sv
design/nx_receiver.sv
design/nx_link_top.sv
dv/tb_nx_link.sv

// File: run.sh
#!/bin/sh
# Build the link testbench with Verilator, run it, and check for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module tb_nx_link -o sim_nx_link || exit 1
out="$(./obj_dir/sim_nx_link)"
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && echo "RESULT: pass" || { echo "RESULT: fail"; exit 1; }
